//--- Bender.yml
package:
  name: hci_queue

sources:
  # Design, in compile order
  - files:
      - source/hci_pkg.sv
      - source/hci_fifo.sv
      - source/hci_cmd_queue.sv
      - source/hci_resp_queue.sv
      - source/hci_csr.sv
      - source/hci_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_hci.sv

//--- sim.f
source/hci_pkg.sv
source/hci_fifo.sv
source/hci_cmd_queue.sv
source/hci_resp_queue.sv
source/hci_csr.sv
source/hci_top.sv
verif/tb_clk_gen.sv
verif/tb_hci.sv

//--- source/hci_cmd_queue.sv
/* HCI command queue */

`timescale 1ns/1ps
`default_nettype none

module hci_cmd_queue
  import hci_pkg::*;
#(
  parameter int unsigned Depth = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Command port from the register block
  input  port_req_t   port_req_i,
  output port_rsp_t   port_rsp_o,
  input  thld_t       thld_i,
  input  logic        rst_req_i,
  output logic        rst_done_o,
  output queue_stat_t stat_o,

  // Controller side
  output logic        cmd_rvalid_o,
  input  logic        cmd_rready_i,
  output cmd_t        cmd_rdata_o
);

  localparam int unsigned CntW = $clog2(Depth + 1);

  logic            half_q;  // Low dword is held
  csr_data_t       low_q;
  logic            rst_done_q;
  logic            flush;
  logic            wr_req;
  logic            push;
  logic            drop;
  logic            pop;
  logic            full;
  logic            empty;
  logic [CntW-1:0] count;
  thld_t           eff_thld;
  thld_t           free_cnt;

  // Flush only on the first cycle of a soft reset
  assign flush  = rst_req_i & ~rst_done_q;
  assign wr_req = port_req_i.req & port_req_i.we;
  assign push   = wr_req & half_q & ~full;
  assign drop   = wr_req & half_q & full;  // Whole command is lost

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q     <= 1'b0;
      rst_done_q <= 1'b0;
    end else begin
      rst_done_q <= flush;
      if (flush) begin
        half_q <= 1'b0;
      end else if (wr_req) begin
        half_q <= ~half_q;  // Second dword pushes or drops
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req && !half_q) low_q <= port_req_i.wdata;
  end

  // Reads are not supported on this port
  assign port_rsp_o.err   = port_req_i.req & (~port_req_i.we | drop);
  assign port_rsp_o.rdata = '0;
  assign rst_done_o       = rst_done_q;

  hci_fifo #(
    .T    (cmd_t),
    .Depth(Depth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .flush_i(flush),
    .push_i (push),
    .wdata_i({port_req_i.wdata, low_q}),
    .pop_i  (pop),
    .rdata_o(cmd_rdata_o),
    .full_o (full),
    .empty_o(empty),
    .count_o(count)
  );

  assign cmd_rvalid_o = ~empty;
  assign pop          = cmd_rvalid_o & cmd_rready_i;

  // Trigger on free space
  assign eff_thld = clamp_thld(thld_i, thld_t'(Depth));
  assign free_cnt = thld_t'(Depth) - thld_t'(count);

  assign stat_o = '{
    full:      full,
    empty:     empty,
    thld_trig: (free_cnt >= eff_thld),
    thld_o:    eff_thld
  };

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_rvalid_o && !cmd_rready_i && !flush |=> cmd_rvalid_o && $stable(cmd_rdata_o))
    else $error("command changed while stalled");

endmodule : hci_cmd_queue

`default_nettype wire

//--- source/hci_csr.sv
/* HCI register block */

`timescale 1ns/1ps
`default_nettype none

module hci_csr
  import hci_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  csr_req_t    csr_req_i,
  output csr_rsp_t    csr_rsp_o,

  // Queue ports
  output port_req_t   cmd_port_o,
  input  port_rsp_t   cmd_port_i,
  output port_req_t   resp_port_o,
  input  port_rsp_t   resp_port_i,

  // Queue control and status
  input  queue_stat_t cmd_stat_i,
  input  queue_stat_t resp_stat_i,
  output thld_t       cmd_thld_o,
  output thld_t       resp_thld_o,
  output logic        cmd_rst_o,
  output logic        resp_rst_o,
  input  logic        cmd_rst_done_i,
  input  logic        resp_rst_done_i
);

  logic      wr;
  logic      rst_wr;
  logic      thld_wr;
  logic      err_d;
  csr_data_t rdata_d;
  thld_t     cmd_thld_q;
  thld_t     resp_thld_q;
  logic      cmd_rst_q;
  logic      resp_rst_q;
  logic      thld_wb_q;  // Clamped values pending
  logic      ack_q;
  logic      err_q;
  csr_data_t rdata_q;

  assign wr      = csr_req_i.req & csr_req_i.we;
  assign rst_wr  = wr & (csr_req_i.addr == ADDR_RESET_CTRL);
  assign thld_wr = wr & (csr_req_i.addr == ADDR_QUEUE_THLD);

  // Port accesses go out as pulses
  assign cmd_port_o.req   = csr_req_i.req & (csr_req_i.addr == ADDR_CMD_PORT);
  assign cmd_port_o.we    = csr_req_i.we;
  assign cmd_port_o.wdata = csr_req_i.wdata;
  assign resp_port_o.req   = csr_req_i.req & (csr_req_i.addr == ADDR_RESP_PORT);
  assign resp_port_o.we    = csr_req_i.we;
  assign resp_port_o.wdata = csr_req_i.wdata;

  always_comb begin
    err_d   = 1'b0;
    rdata_d = '0;
    case (csr_req_i.addr)
      ADDR_RESET_CTRL: begin
        rdata_d[RST_CMD_BIT]  = cmd_rst_q;
        rdata_d[RST_RESP_BIT] = resp_rst_q;
      end
      ADDR_CMD_PORT: begin
        err_d   = cmd_port_i.err;
        rdata_d = cmd_port_i.rdata;
      end
      ADDR_RESP_PORT: begin
        err_d   = resp_port_i.err;
        rdata_d = resp_port_i.rdata;
      end
      ADDR_QUEUE_THLD: begin
        rdata_d[THLD_CMD_LSB +: ThldW]  = cmd_thld_q;
        rdata_d[THLD_RESP_LSB +: ThldW] = resp_thld_q;
      end
      ADDR_QUEUE_STATUS: begin
        rdata_d[STAT_CMD_FULL]   = cmd_stat_i.full;
        rdata_d[STAT_CMD_EMPTY]  = cmd_stat_i.empty;
        rdata_d[STAT_CMD_TRIG]   = cmd_stat_i.thld_trig;
        rdata_d[STAT_RESP_FULL]  = resp_stat_i.full;
        rdata_d[STAT_RESP_EMPTY] = resp_stat_i.empty;
        rdata_d[STAT_RESP_TRIG]  = resp_stat_i.thld_trig;
      end
      default: err_d = 1'b1;  // Unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      rdata_q     <= '0;
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
      thld_wb_q   <= 1'b0;
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
    end else begin
      ack_q     <= csr_req_i.req;
      err_q     <= csr_req_i.req & err_d;
      rdata_q   <= (csr_req_i.req && !csr_req_i.we) ? rdata_d : '0;
      thld_wb_q <= thld_wr;
      if (thld_wr) begin
        cmd_thld_q  <= csr_req_i.wdata[THLD_CMD_LSB +: ThldW];
        resp_thld_q <= csr_req_i.wdata[THLD_RESP_LSB +: ThldW];
      end else if (thld_wb_q) begin
        cmd_thld_q  <= cmd_stat_i.thld_o;  // Clamped by the queue
        resp_thld_q <= resp_stat_i.thld_o;
      end
      if (rst_wr) begin
        cmd_rst_q  <= csr_req_i.wdata[RST_CMD_BIT];
        resp_rst_q <= csr_req_i.wdata[RST_RESP_BIT];
      end else begin
        if (cmd_rst_done_i) cmd_rst_q <= 1'b0;
        if (resp_rst_done_i) resp_rst_q <= 1'b0;
      end
    end
  end

  assign csr_rsp_o   = '{ack: ack_q, err: err_q, rdata: rdata_q};
  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;
  assign cmd_rst_o   = cmd_rst_q;
  assign resp_rst_o  = resp_rst_q;

  // Ack is a single pulse in the cycle after each request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_req_i.req |=> csr_rsp_o.ack ##1 !csr_rsp_o.ack)
    else $error("acknowledge is not a single pulse after the request");

endmodule : hci_csr

`default_nettype wire

//--- source/hci_fifo.sv
/* Fall-through FIFO */

`timescale 1ns/1ps
`default_nettype none

module hci_fifo #(
  parameter type         T     = logic [31:0],
  parameter int unsigned Depth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,  // Drops every entry
  input  logic                           push_i,
  input  T                               wdata_i,
  input  logic                           pop_i,
  output T                               rdata_o,  // Head of the queue
  output logic                           full_o,
  output logic                           empty_o,
  output logic [$clog2(Depth + 1) - 1:0] count_o
);

  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  T                 mem_q [Depth];
  logic [AddrW-1:0] wptr_q;
  logic [AddrW-1:0] rptr_q;
  logic [CntW-1:0]  count_q;

  // Wraps at Depth, so any depth works
  function automatic logic [AddrW-1:0] next_ptr(logic [AddrW-1:0] ptr);
    return (ptr == AddrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) wptr_q <= next_ptr(wptr_q);
      if (pop_i) rptr_q <= next_ptr(rptr_q);
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wptr_q] <= wdata_i;
  end

  assign rdata_o = mem_q[rptr_q];
  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  // Callers must respect full and empty
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into a full FIFO");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("pop from an empty FIFO");

endmodule : hci_fifo

`default_nettype wire

//--- source/hci_pkg.sv
/* HCI queue block definitions */

`default_nettype none

package hci_pkg;

  localparam int unsigned CsrAddrW = 12;
  localparam int unsigned CsrDataW = 32;
  localparam int unsigned ThldW    = 8;

  typedef logic [CsrAddrW-1:0] csr_addr_t;
  typedef logic [CsrDataW-1:0] csr_data_t;
  typedef logic [ThldW-1:0]    thld_t;
  typedef logic [63:0]         cmd_t;
  typedef logic [31:0]         resp_t;

  // Register map
  localparam csr_addr_t ADDR_RESET_CTRL   = 12'h004;
  localparam csr_addr_t ADDR_CMD_PORT     = 12'h00C;
  localparam csr_addr_t ADDR_RESP_PORT    = 12'h010;
  localparam csr_addr_t ADDR_QUEUE_THLD   = 12'h014;
  localparam csr_addr_t ADDR_QUEUE_STATUS = 12'h018;

  localparam int unsigned RST_CMD_BIT   = 1;
  localparam int unsigned RST_RESP_BIT  = 2;
  localparam int unsigned THLD_CMD_LSB  = 0;
  localparam int unsigned THLD_RESP_LSB = 8;

  // QUEUE_STATUS fields
  localparam int unsigned STAT_CMD_FULL   = 0;
  localparam int unsigned STAT_CMD_EMPTY  = 1;
  localparam int unsigned STAT_CMD_TRIG   = 2;
  localparam int unsigned STAT_RESP_FULL  = 3;
  localparam int unsigned STAT_RESP_EMPTY = 4;
  localparam int unsigned STAT_RESP_TRIG  = 5;

  typedef struct packed {
    logic      req;
    logic      we;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    logic      ack;
    logic      err;
    csr_data_t rdata;
  } csr_rsp_t;

  // Decoded port access towards a queue
  typedef struct packed {
    logic      req;
    logic      we;
    csr_data_t wdata;
  } port_req_t;

  typedef struct packed {
    logic      err;
    csr_data_t rdata;
  } port_rsp_t;

  typedef struct packed {
    logic  full;
    logic  empty;
    logic  thld_trig;
    thld_t thld_o;  // Effective threshold after clamping
  } queue_stat_t;

  // Zero acts as one, anything past the depth is held at the depth
  function automatic thld_t clamp_thld(thld_t thld, thld_t depth);
    if (thld == '0) return thld_t'(1);
    if (thld > depth) return depth;
    return thld;
  endfunction

endpackage : hci_pkg

`default_nettype wire

//--- source/hci_resp_queue.sv
/* HCI response queue */

`timescale 1ns/1ps
`default_nettype none

module hci_resp_queue
  import hci_pkg::*;
#(
  parameter int unsigned Depth = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Response port from the register block
  input  port_req_t   port_req_i,
  output port_rsp_t   port_rsp_o,
  input  thld_t       thld_i,
  input  logic        rst_req_i,
  output logic        rst_done_o,
  output queue_stat_t stat_o,

  // Controller side
  input  logic        resp_wvalid_i,
  output logic        resp_wready_o,
  input  resp_t       resp_wdata_i
);

  localparam int unsigned CntW = $clog2(Depth + 1);

  logic            rst_done_q;
  logic            flush;
  logic            rd_req;
  logic            push;
  logic            pop;
  logic            full;
  logic            empty;
  resp_t           head;
  logic [CntW-1:0] count;
  thld_t           eff_thld;

  assign flush = rst_req_i & ~rst_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_done_q <= 1'b0;
    end else begin
      rst_done_q <= flush;  // Done one cycle after the flush
    end
  end

  assign rst_done_o = rst_done_q;

  // Port read pops the head straight away
  assign rd_req = port_req_i.req & ~port_req_i.we;
  assign pop    = rd_req & ~empty;

  assign port_rsp_o.err   = port_req_i.req & (port_req_i.we | empty);
  assign port_rsp_o.rdata = pop ? head : '0;

  assign resp_wready_o = ~full;
  assign push          = resp_wvalid_i & ~full;

  hci_fifo #(
    .T    (resp_t),
    .Depth(Depth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .flush_i(flush),
    .push_i (push),
    .wdata_i(resp_wdata_i),
    .pop_i  (pop),
    .rdata_o(head),
    .full_o (full),
    .empty_o(empty),
    .count_o(count)
  );

  // Trigger on filled entries
  assign eff_thld = clamp_thld(thld_i, thld_t'(Depth));

  assign stat_o = '{
    full:      full,
    empty:     empty,
    thld_trig: (thld_t'(count) >= eff_thld),
    thld_o:    eff_thld
  };

endmodule : hci_resp_queue

`default_nettype wire

//--- source/hci_top.sv
/* HCI queue block top level */

`timescale 1ns/1ps
`default_nettype none

module hci_top
  import hci_pkg::*;
#(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Register bus
  input  csr_req_t    csr_req_i,
  output csr_rsp_t    csr_rsp_o,

  // Controller side
  output logic        cmd_rvalid_o,
  input  logic        cmd_rready_i,
  output cmd_t        cmd_rdata_o,
  input  logic        resp_wvalid_i,
  output logic        resp_wready_o,
  input  resp_t       resp_wdata_i,

  output queue_stat_t cmd_stat_o,
  output queue_stat_t resp_stat_o
);

  port_req_t cmd_port_req;
  port_rsp_t cmd_port_rsp;
  port_req_t resp_port_req;
  port_rsp_t resp_port_rsp;
  thld_t     cmd_thld;
  thld_t     resp_thld;
  logic      cmd_rst;
  logic      resp_rst;
  logic      cmd_rst_done;
  logic      resp_rst_done;

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_port_o     (cmd_port_req),
    .cmd_port_i     (cmd_port_rsp),
    .resp_port_o    (resp_port_req),
    .resp_port_i    (resp_port_rsp),
    .cmd_stat_i     (cmd_stat_o),
    .resp_stat_i    (resp_stat_o),
    .cmd_thld_o     (cmd_thld),
    .resp_thld_o    (resp_thld),
    .cmd_rst_o      (cmd_rst),
    .resp_rst_o     (resp_rst),
    .cmd_rst_done_i (cmd_rst_done),
    .resp_rst_done_i(resp_rst_done)
  );

  hci_cmd_queue #(
    .Depth(CmdDepth)
  ) u_cmd_queue (
    .clk_i,
    .rst_ni,
    .port_req_i(cmd_port_req),
    .port_rsp_o(cmd_port_rsp),
    .thld_i    (cmd_thld),
    .rst_req_i (cmd_rst),
    .rst_done_o(cmd_rst_done),
    .stat_o    (cmd_stat_o),
    .cmd_rvalid_o,
    .cmd_rready_i,
    .cmd_rdata_o
  );

  hci_resp_queue #(
    .Depth(RespDepth)
  ) u_resp_queue (
    .clk_i,
    .rst_ni,
    .port_req_i(resp_port_req),
    .port_rsp_o(resp_port_rsp),
    .thld_i    (resp_thld),
    .rst_req_i (resp_rst),
    .rst_done_o(resp_rst_done),
    .stat_o    (resp_stat_o),
    .resp_wvalid_i,
    .resp_wready_o,
    .resp_wdata_i
  );

endmodule : hci_top

`default_nettype wire

//--- verif/tb_clk_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;  // Released on a rising edge
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- verif/tb_hci.sv
/* HCI queue block testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_hci
  import hci_pkg::*;
();

  localparam int unsigned Depth    = 8;
  localparam int unsigned Timeout  = 50;
  localparam int unsigned MaxSteps = 128;

  localparam logic [2:0] OpWrite = 3'd0;
  localparam logic [2:0] OpRead  = 3'd1;
  localparam logic [2:0] OpPop   = 3'd2;  // Controller takes a command
  localparam logic [2:0] OpPush  = 3'd3;  // Controller gives a response
  localparam logic [2:0] OpPoll  = 3'd4;

  typedef struct packed {
    logic [2:0]  op;
    logic [3:0]  test;
    csr_addr_t   addr;
    logic [63:0] data;
    logic [63:0] exp_data;
    logic        exp_err;  // For a push this means wready is expected low
  } step_t;

  logic        clk;
  logic        rst_n;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;
  logic        cmd_rvalid;
  logic        cmd_rready;
  cmd_t        cmd_rdata;
  logic        resp_wvalid;
  logic        resp_wready;
  resp_t       resp_wdata;
  queue_stat_t cmd_stat;
  queue_stat_t resp_stat;

  step_t       steps [MaxSteps];
  int unsigned n_steps;
  int unsigned checks;
  int unsigned errors;
  string       test_name [1:5];
  logic [31:0] rng_state;

  // Queue model
  cmd_t        mdl_cmd [$];
  resp_t       mdl_resp [$];
  thld_t       cmd_thld_reg;
  thld_t       resp_thld_reg;

  tb_clk_gen #(.PeriodNs(10), .ResetCycles(10)) u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  hci_top #(
    .CmdDepth (Depth),
    .RespDepth(Depth)
  ) u_hci_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_req_i    (csr_req),
    .csr_rsp_o    (csr_rsp),
    .cmd_rvalid_o (cmd_rvalid),
    .cmd_rready_i (cmd_rready),
    .cmd_rdata_o  (cmd_rdata),
    .resp_wvalid_i(resp_wvalid),
    .resp_wready_o(resp_wready),
    .resp_wdata_i (resp_wdata),
    .cmd_stat_o   (cmd_stat),
    .resp_stat_o  (resp_stat)
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Zero means one, values past the depth saturate
  function automatic thld_t expected_thld(thld_t v);
    if (v == 0) return 1;
    if (v > Depth) return Depth;
    return v;
  endfunction

  function automatic void add_step(logic [2:0] op, logic [3:0] test, csr_addr_t addr,
                                   logic [63:0] data, logic [63:0] exp_data, logic exp_err);
    steps[n_steps] = '{op: op, test: test, addr: addr, data: data,
                       exp_data: exp_data, exp_err: exp_err};
    n_steps++;
  endfunction

  function automatic csr_data_t status_word();
    csr_data_t   w;
    int unsigned cmd_n;
    int unsigned resp_n;
    w = '0;
    cmd_n = mdl_cmd.size();
    resp_n = mdl_resp.size();
    w[STAT_CMD_FULL]   = (cmd_n == Depth);
    w[STAT_CMD_EMPTY]  = (cmd_n == 0);
    w[STAT_CMD_TRIG]   = ((Depth - cmd_n) >= expected_thld(cmd_thld_reg));  // Free entries
    w[STAT_RESP_FULL]  = (resp_n == Depth);
    w[STAT_RESP_EMPTY] = (resp_n == 0);
    w[STAT_RESP_TRIG]  = (resp_n >= expected_thld(resp_thld_reg));
    return w;
  endfunction

  // Low dword first, the second write completes or drops the command
  function automatic void cmd_write(logic [3:0] test, cmd_t cmd);
    logic full;
    full = (mdl_cmd.size() == Depth);
    add_step(OpWrite, test, ADDR_CMD_PORT, cmd[31:0], '0, 1'b0);
    add_step(OpWrite, test, ADDR_CMD_PORT, cmd[63:32], '0, full);
    if (!full) mdl_cmd.push_back(cmd);
  endfunction

  function automatic void cmd_pop(logic [3:0] test);
    add_step(OpPop, test, '0, '0, mdl_cmd.pop_front(), 1'b0);
  endfunction

  function automatic void resp_push(logic [3:0] test, resp_t r);
    logic full;
    full = (mdl_resp.size() == Depth);
    add_step(OpPush, test, '0, r, '0, full);
    if (!full) mdl_resp.push_back(r);
  endfunction

  function automatic void port_read(logic [3:0] test, csr_addr_t addr);
    if (addr == ADDR_RESP_PORT && mdl_resp.size() != 0) begin
      add_step(OpRead, test, addr, '0, mdl_resp.pop_front(), 1'b0);
    end else begin
      add_step(OpRead, test, addr, '0, '0, 1'b1);  // Empty, write-only or unmapped
    end
  endfunction

  // Register word in the low dword, both status outputs above it
  function automatic void status_read(logic [3:0] test);
    csr_data_t   w;
    queue_stat_t cs;
    queue_stat_t rs;
    w  = status_word();
    cs = '{full: w[STAT_CMD_FULL], empty: w[STAT_CMD_EMPTY], thld_trig: w[STAT_CMD_TRIG],
           thld_o: expected_thld(cmd_thld_reg)};
    rs = '{full: w[STAT_RESP_FULL], empty: w[STAT_RESP_EMPTY], thld_trig: w[STAT_RESP_TRIG],
           thld_o: expected_thld(resp_thld_reg)};
    add_step(OpRead, test, ADDR_QUEUE_STATUS, '0, {10'h0, cs, rs, w}, 1'b0);
  endfunction

  function automatic void thld_write(logic [3:0] test, thld_t cmd_v, thld_t resp_v);
    add_step(OpWrite, test, ADDR_QUEUE_THLD, {48'h0, resp_v, cmd_v}, '0, 1'b0);
    cmd_thld_reg  = expected_thld(cmd_v);
    resp_thld_reg = expected_thld(resp_v);
  endfunction

  function automatic void thld_read(logic [3:0] test);
    add_step(OpRead, test, ADDR_QUEUE_THLD, '0, {48'h0, resp_thld_reg, cmd_thld_reg}, 1'b0);
  endfunction

  function automatic void queue_reset(logic [3:0] test, logic do_cmd, logic do_resp);
    logic [63:0] mask;
    mask = '0;
    mask[RST_CMD_BIT]  = do_cmd;
    mask[RST_RESP_BIT] = do_resp;
    add_step(OpWrite, test, ADDR_RESET_CTRL, mask, '0, 1'b0);
    add_step(OpPoll, test, ADDR_RESET_CTRL, mask, '0, 1'b0);
    if (do_cmd) mdl_cmd.delete();
    if (do_resp) mdl_resp.delete();
  endfunction

  function automatic void build_table();
    thld_read(1);
    status_read(1);
    for (int i = 0; i < 4; i++) cmd_write(1, {xorshift32(), xorshift32()});
    for (int i = 0; i < 4; i++) cmd_pop(1);
    for (int i = 0; i < 4; i++) resp_push(2, xorshift32());
    for (int i = 0; i < 5; i++) port_read(2, ADDR_RESP_PORT);  // Last one finds it empty
    port_read(2, 12'h020);
    port_read(2, ADDR_CMD_PORT);
    for (int i = 0; i < 9; i++) cmd_write(3, {xorshift32(), xorshift32()});
    for (int i = 0; i < 9; i++) resp_push(3, xorshift32());
    status_read(3);
    for (int i = 0; i < 8; i++) cmd_pop(3);
    for (int i = 0; i < 8; i++) port_read(3, ADDR_RESP_PORT);
    status_read(3);
    thld_write(4, 8'd0, 8'd200);
    thld_read(4);
    thld_write(4, 8'd6, 8'd3);
    thld_read(4);
    for (int i = 0; i < 4; i++) begin
      resp_push(4, xorshift32());
      status_read(4);
    end
    for (int i = 0; i < 4; i++) begin
      cmd_write(4, {xorshift32(), xorshift32()});
      status_read(4);
    end
    queue_reset(5, 1'b1, 1'b1);
    status_read(5);
  endfunction

  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    errors++;
  endtask

  // One request pulse, then wait for the acknowledge
  task automatic csr_access(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                            output csr_data_t rdata, output logic err, output logic ok);
    int unsigned waited;
    @(posedge clk);
    csr_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(posedge clk);
    csr_req <= '0;
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < Timeout) begin
      @(negedge clk);
      if (csr_rsp.ack) ok = 1'b1;
      else waited++;
    end
    rdata = csr_rsp.rdata;
    err = csr_rsp.err;
    if (!ok) report_timeout("a register acknowledge");
  endtask

  task automatic drive_pop(cmd_t exp);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!cmd_rvalid && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_rvalid) begin
      report_timeout("cmd_rvalid_o");
    end else begin
      check_value("command data", cmd_rdata, exp);
      @(posedge clk);
      cmd_rready <= 1'b1;
      @(posedge clk);
      cmd_rready <= 1'b0;
    end
  endtask

  task automatic drive_push(resp_t data, logic exp_stall);
    @(negedge clk);
    check_value("resp_wready_o", resp_wready, !exp_stall);
    @(posedge clk);
    resp_wvalid <= 1'b1;
    resp_wdata  <= data;
    @(posedge clk);
    resp_wvalid <= 1'b0;
  endtask

  task automatic run_step(step_t s);
    csr_data_t   rdata;
    logic        err;
    logic        ok;
    int unsigned tries;
    case (s.op)
      OpWrite: begin
        csr_access(1'b1, s.addr, s.data[31:0], rdata, err, ok);
        if (ok) check_value($sformatf("write 0x%03h err", s.addr), err, s.exp_err);
      end
      OpRead: begin
        csr_access(1'b0, s.addr, '0, rdata, err, ok);
        if (ok) begin
          check_value($sformatf("read 0x%03h err", s.addr), err, s.exp_err);
          check_value($sformatf("read 0x%03h data", s.addr), rdata, s.exp_data[31:0]);
          if (s.addr == ADDR_QUEUE_STATUS) begin
            check_value("cmd_stat_o", cmd_stat, s.exp_data[53:43]);
            check_value("resp_stat_o", resp_stat, s.exp_data[42:32]);
          end
        end
      end
      OpPop: drive_pop(s.exp_data);
      OpPush: drive_push(s.data[31:0], s.exp_err);
      OpPoll: begin
        tries = 0;
        ok = 1'b1;
        rdata = s.data[31:0];
        while (ok && (rdata & s.data[31:0]) != '0 && tries < Timeout) begin
          csr_access(1'b0, s.addr, '0, rdata, err, ok);
          tries++;
        end
        if (ok && (rdata & s.data[31:0]) != '0) report_timeout("the reset bits to clear");
      end
      default: begin
        $display("Unknown table operation %0d", s.op);
        errors++;
      end
    endcase
  endtask

  initial begin
    int unsigned waited;
    int unsigned test_errs;
    csr_req     = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    rng_state   = 32'd39;
    n_steps     = 0;
    checks      = 0;
    errors      = 0;
    test_errs   = 0;
    cmd_thld_reg  = '0;
    resp_thld_reg = '0;
    test_name[1] = "command order";
    test_name[2] = "response order and port errors";
    test_name[3] = "full queues";
    test_name[4] = "thresholds and triggers";
    test_name[5] = "soft reset";
    build_table();

    waited = 0;
    while (rst_n !== 1'b1 && waited < Timeout) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) report_timeout("reset release");

    for (int i = 0; i < n_steps; i++) begin
      run_step(steps[i]);
      if (i == n_steps - 1 || steps[i + 1].test != steps[i].test) begin
        $display("Test %0d %s: %s", steps[i].test, test_name[steps[i].test],
                 (errors == test_errs) ? "ok" : "with errors");
        test_errs = errors;
      end
    end

    $display("Steps %0d, checks %0d, errors %0d", n_steps, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_hci

`default_nettype wire
